// File: source/bch_pkg.sv
// field and code constants, register address map, GF(2^6) helper functions
package bch_pkg;

	//----------------------------------------------------------
	// field and code
	//----------------------------------------------------------
	localparam int GF_M = 6;                           // GF(64)
	localparam int FIELD_N = (1 << GF_M) - 1;          // order of alpha
	localparam logic [GF_M:0] PRIM_POLY = 7'b1000011;  // x^6+x+1
	localparam int CODE_T = 4;                         // design correction capability
	localparam int NUM_ODD = CODE_T;
	localparam int NUM_SYN = 2 * CODE_T;
	localparam int BEAT_W = 16;
	localparam int T_W = 3;
	localparam int CNT_W = 16;
	localparam int REG_W = 16;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0, // [0] enable, [3:1] t_active
		REG_FRAMES = 2'd1, // frames seen, read only
		REG_ERRS   = 2'd2, // frames with error, read only
		REG_CLEAR  = 2'd3  // write clears both counters
	} reg_addr_e;

	//----------------------------------------------------------
	// GF(2^6) arithmetic
	//----------------------------------------------------------
	// multiply by alpha, reduce by the primitive polynomial
	function automatic logic [GF_M-1:0] gf_times_alpha(input logic [GF_M-1:0] a);
		return {a[GF_M-2:0], 1'b0} ^ (a[GF_M-1] ? PRIM_POLY[GF_M-1:0] : '0);
	endfunction

	function automatic logic [GF_M-1:0] gf_mul(
		input logic [GF_M-1:0] a,
		input logic [GF_M-1:0] b
	);
		logic [GF_M-1:0] p;
		p = '0;
		for (int i = GF_M - 1; i >= 0; i--)
		begin
			p = gf_times_alpha(p); // horner over the bits of b
			if (b[i])
				p = p ^ a;
		end
		return p;
	endfunction

	function automatic logic [GF_M-1:0] gf_pow_alpha(input int e);
		logic [GF_M-1:0] v;
		v = GF_M'(1);
		for (int i = 0; i < e % FIELD_N; i++)
			v = gf_times_alpha(v);
		return v;
	endfunction

	// product of (x + alpha^e) over the cyclotomic coset of idx
	function automatic logic [GF_M:0] min_poly(input int idx);
		logic [GF_M-1:0] coef [GF_M+1];
		logic [FIELD_N-1:0] seen;
		logic [GF_M-1:0] root;
		logic [GF_M:0] poly;
		int e;
		for (int k = 0; k <= GF_M; k++)
			coef[k] = '0;
		coef[0] = GF_M'(1);
		seen = '0;
		e = idx % FIELD_N;
		for (int j = 0; j < GF_M; j++)
		begin
			if (!seen[e])
			begin
				seen[e] = 1'b1;
				root = gf_pow_alpha(e);
				for (int k = GF_M; k > 0; k--)
					coef[k] = coef[k-1] ^ gf_mul(coef[k], root);
				coef[0] = gf_mul(coef[0], root);
			end
			e = (2 * e) % FIELD_N;
		end
		for (int k = 0; k <= GF_M; k++)
			poly[k] = (coef[k] == GF_M'(1)); // coefficients land in GF(2)
		return poly;
	endfunction

	// row k of the remainder-to-syndrome matrix: bit k of alpha^(idx*j)
	function automatic logic [GF_M-1:0] transform_row(input int idx, input int k);
		logic [GF_M-1:0] row;
		logic [GF_M-1:0] pw;
		for (int j = 0; j < GF_M; j++)
		begin
			pw = gf_pow_alpha(idx * j);
			row[j] = pw[k];
		end
		return row;
	endfunction

endpackage

// File: source/bch_ctrl_if.sv
// control and status signals between register block and syndrome core
interface bch_ctrl_if;
	import bch_pkg::*;

	logic enable;             // gates input beats
	logic [T_W-1:0] t_active; // live correction capability
	logic frame_done;         // one strobe per frame result
	logic frame_err;          // result had a nonzero syndrome

	// register block side
	modport regs (
		output enable,
		output t_active,
		input  frame_done,
		input  frame_err
	);

	// syndrome core side
	modport core (
		input  enable,
		input  t_active,
		output frame_done,
		output frame_err
	);

endinterface

// File: source/bch_syndrome_calc.sv
// beat-wise division by the odd minimal polynomials, end-of-frame transform to odd syndromes
module bch_syndrome_calc (
	input  logic                                              I_clk,
	input  logic                                              rst_n_i,
	input  logic [bch_pkg::BEAT_W-1:0]                        data_i,   // first bit in msb
	input  logic                                              data_v_i,
	input  logic                                              sof_i,
	input  logic                                              eof_i,
	bch_ctrl_if.core                                          ctrl,
	output logic [bch_pkg::NUM_ODD-1:0][bch_pkg::GF_M-1:0]    odd_syn_o,
	output logic                                              odd_syn_v_o
);
	import bch_pkg::*;

	// one beat of long division, msb first, remainder stays below deg(poly)
	function automatic logic [GF_M-1:0] rem_update(
		input logic [GF_M-1:0] rem,
		input logic [BEAT_W-1:0] beat,
		input logic [GF_M:0] poly
	);
		logic [GF_M:0] acc;
		int deg;
		deg = 0;
		for (int k = 0; k <= GF_M; k++)
		begin
			if (poly[k])
				deg = k;
		end
		acc = {1'b0, rem};
		for (int i = BEAT_W - 1; i >= 0; i--)
		begin
			acc = {acc[GF_M-1:0], beat[i]};
			if (acc[deg])
				acc = acc ^ poly; // clears the leading term
		end
		return acc[GF_M-1:0];
	endfunction

	logic accept;
	logic [BEAT_W-1:0] beat_q;
	logic beat_v_q;
	logic sof_q;
	logic eof_q;
	logic eof_d1;
	logic eof_d2;

	assign accept = data_v_i & ctrl.enable;

	//----------------------------------------------------------
	// capture stage
	//----------------------------------------------------------
	always_ff @(posedge I_clk)
	begin
		beat_q <= data_i;
	end

	// frame flags only count on accepted beats
	always_ff @(posedge I_clk)
	begin
		if (!rst_n_i)
		begin
			beat_v_q    <= 1'b0;
			sof_q       <= 1'b0;
			eof_q       <= 1'b0;
			eof_d1      <= 1'b0;
			eof_d2      <= 1'b0;
			odd_syn_v_o <= 1'b0;
		end
		else
		begin
			beat_v_q    <= accept;
			sof_q       <= accept & sof_i;
			eof_q       <= accept & eof_i;
			eof_d1      <= eof_q;  // remainders final
			eof_d2      <= eof_d1; // held copy valid
			odd_syn_v_o <= eof_d2;
		end
	end

	//----------------------------------------------------------
	// per odd index: update, hold, transform
	//----------------------------------------------------------
	genvar gi;
	generate
		for (gi = 0; gi < NUM_ODD; gi++)
		begin : g_odd
			logic [GF_M-1:0] rem_q;
			logic [GF_M-1:0] rem_base;
			logic [GF_M-1:0] hold_q;
			logic [GF_M-1:0] syn_q;

			assign rem_base = sof_q ? '0 : rem_q; // restart on start of frame

			always_ff @(posedge I_clk)
			begin
				if (beat_v_q)
					rem_q <= rem_update(rem_base, beat_q, min_poly(2 * gi + 1));
			end

			// keeps the finished remainder so a back-to-back frame can start
			always_ff @(posedge I_clk)
			begin
				if (eof_d1)
					hold_q <= rem_q;
			end

			// S(2gi+1) = r(alpha^(2gi+1)), one parity per output bit
			always_ff @(posedge I_clk)
			begin
				if (eof_d2)
				begin
					for (int k = 0; k < GF_M; k++)
						syn_q[k] <= ^(hold_q & transform_row(2 * gi + 1, k));
				end
			end

			assign odd_syn_o[gi] = syn_q;
		end
	endgenerate

endmodule

// File: source/bch_syndrome_expand.sv
// even syndromes by squaring, t_active masking, error flag, registered outputs
module bch_syndrome_expand (
	input  logic                                              I_clk,
	input  logic                                              rst_n_i,
	input  logic [bch_pkg::NUM_ODD-1:0][bch_pkg::GF_M-1:0]    odd_syn_i,
	input  logic                                              odd_syn_v_i,
	bch_ctrl_if.core                                          ctrl,
	output logic [bch_pkg::NUM_SYN*bch_pkg::GF_M-1:0]         syndrome_o, // S1 in low bits
	output logic                                              syndrome_v_o,
	output logic                                              err_o
);
	import bch_pkg::*;

	logic [GF_M-1:0] syn_full [NUM_SYN]; // entry 0 is S1
	logic [NUM_SYN*GF_M-1:0] syn_masked;
	logic any_nz;

	// odd ones straight through, S(2i) = S(i)^2
	always_comb
	begin
		for (int j = 1; j <= NUM_SYN; j++)
		begin
			if (j % 2 == 1)
				syn_full[j-1] = odd_syn_i[(j-1)/2];
			else
				syn_full[j-1] = gf_mul(syn_full[j/2-1], syn_full[j/2-1]);
		end
	end

	// only the first 2*t_active syndromes are live
	always_comb
	begin
		syn_masked = '0;
		for (int j = 1; j <= NUM_SYN; j++)
		begin
			if (j <= 2 * int'(ctrl.t_active))
				syn_masked[(j-1)*GF_M +: GF_M] = syn_full[j-1];
		end
	end

	assign any_nz = |syn_masked;

	//----------------------------------------------------------
	// output registers
	//----------------------------------------------------------
	always_ff @(posedge I_clk)
	begin
		if (odd_syn_v_i)
			syndrome_o <= syn_masked; // holds until next result
	end

	always_ff @(posedge I_clk)
	begin
		if (!rst_n_i)
		begin
			syndrome_v_o <= 1'b0;
			err_o        <= 1'b0;
		end
		else
		begin
			syndrome_v_o <= odd_syn_v_i;
			err_o        <= odd_syn_v_i & any_nz;
		end
	end

	// status back to the counters
	assign ctrl.frame_done = syndrome_v_o;
	assign ctrl.frame_err  = err_o;

endmodule

// File: source/bch_regs.sv
// control register, frame and error counters, register read port
module bch_regs (
	input  logic                         I_clk,
	input  logic                         rst_n_i,
	input  logic                         reg_wr_i,
	input  logic                         reg_rd_i,
	input  bch_pkg::reg_addr_e           reg_addr_i,
	input  logic [bch_pkg::REG_W-1:0]    reg_wdata_i,
	output logic [bch_pkg::REG_W-1:0]    reg_rdata_o,
	output logic                         reg_rvalid_o,
	bch_ctrl_if.regs                     ctrl
);
	import bch_pkg::*;

	logic enable_q;
	logic [T_W-1:0] t_active_q;
	logic [CNT_W-1:0] frames_q;
	logic [CNT_W-1:0] errs_q;
	logic [T_W-1:0] t_field;
	logic [T_W-1:0] t_clamp;
	logic ctrl_wr;
	logic clear_wr;

	assign ctrl_wr  = reg_wr_i && (reg_addr_i == REG_CTRL);
	assign clear_wr = reg_wr_i && (reg_addr_i == REG_CLEAR);

	// zero or above design capability falls back to CODE_T
	assign t_field = reg_wdata_i[T_W:1];
	assign t_clamp = (t_field == '0 || int'(t_field) > CODE_T) ? T_W'(CODE_T) : t_field;

	//----------------------------------------------------------
	// control register
	//----------------------------------------------------------
	always_ff @(posedge I_clk)
	begin
		if (!rst_n_i)
		begin
			enable_q   <= 1'b1;
			t_active_q <= T_W'(CODE_T);
		end
		else if (ctrl_wr)
		begin
			enable_q   <= reg_wdata_i[0];
			t_active_q <= t_clamp;
		end
	end

	assign ctrl.enable   = enable_q;
	assign ctrl.t_active = t_active_q;

	//----------------------------------------------------------
	// counters, wrap around, clear wins over increment
	//----------------------------------------------------------
	always_ff @(posedge I_clk)
	begin
		if (!rst_n_i || clear_wr)
		begin
			frames_q <= '0;
			errs_q   <= '0;
		end
		else
		begin
			if (ctrl.frame_done)
				frames_q <= frames_q + 1'b1;
			if (ctrl.frame_done && ctrl.frame_err)
				errs_q <= errs_q + 1'b1;
		end
	end

	// read data one cycle after the strobe
	always_ff @(posedge I_clk)
	begin
		if (!rst_n_i)
			reg_rvalid_o <= 1'b0;
		else
			reg_rvalid_o <= reg_rd_i;
	end

	always_ff @(posedge I_clk)
	begin
		if (reg_rd_i)
		begin
			case (reg_addr_i)
				REG_CTRL:   reg_rdata_o <= REG_W'({t_active_q, enable_q});
				REG_FRAMES: reg_rdata_o <= REG_W'(frames_q);
				REG_ERRS:   reg_rdata_o <= REG_W'(errs_q);
				default:    reg_rdata_o <= '0; // clear address reads zero
			endcase
		end
	end

endmodule

// File: source/bch_syndrome_top.sv
// syndrome front end top level with register block, calc and expand stages
module bch_syndrome_top (
	input  logic                                              I_clk,
	input  logic                                              rst_n_i,
	// beat stream
	input  logic [bch_pkg::BEAT_W-1:0]                        data_i,
	input  logic                                              data_v_i,
	input  logic                                              sof_i,
	input  logic                                              eof_i,
	// register strobes
	input  logic                                              reg_wr_i,
	input  logic                                              reg_rd_i,
	input  bch_pkg::reg_addr_e                                reg_addr_i,
	input  logic [bch_pkg::REG_W-1:0]                         reg_wdata_i,
	// results
	output logic [bch_pkg::NUM_SYN*bch_pkg::GF_M-1:0]         syndrome_o,
	output logic                                              syndrome_v_o,
	output logic                                              err_o,
	output logic [bch_pkg::REG_W-1:0]                         reg_rdata_o,
	output logic                                              reg_rvalid_o
);
	import bch_pkg::*;

	logic [NUM_ODD-1:0][GF_M-1:0] odd_syn;
	logic odd_syn_v;

	bch_ctrl_if ctrl_if ();

	bch_regs u_regs (
		.I_clk        (I_clk),
		.rst_n_i      (rst_n_i),
		.reg_wr_i     (reg_wr_i),
		.reg_rd_i     (reg_rd_i),
		.reg_addr_i   (reg_addr_i),
		.reg_wdata_i  (reg_wdata_i),
		.reg_rdata_o  (reg_rdata_o),
		.reg_rvalid_o (reg_rvalid_o),
		.ctrl         (ctrl_if.regs)
	);

	bch_syndrome_calc u_calc (
		.I_clk       (I_clk),
		.rst_n_i     (rst_n_i),
		.data_i      (data_i),
		.data_v_i    (data_v_i),
		.sof_i       (sof_i),
		.eof_i       (eof_i),
		.ctrl        (ctrl_if.core),
		.odd_syn_o   (odd_syn),
		.odd_syn_v_o (odd_syn_v)
	);

	bch_syndrome_expand u_expand (
		.I_clk        (I_clk),
		.rst_n_i      (rst_n_i),
		.odd_syn_i    (odd_syn),
		.odd_syn_v_i  (odd_syn_v),
		.ctrl         (ctrl_if.core),
		.syndrome_o   (syndrome_o),
		.syndrome_v_o (syndrome_v_o),
		.err_o        (err_o)
	);

endmodule

// File: verif/bch_syndrome_sva.sv
// assertions on result strobes and register read timing, bound to the syndrome top level
module bch_syndrome_sva (
	input logic I_clk,
	input logic rst_n_i,
	input logic syn_v_i,
	input logic err_i,
	input logic rd_i,
	input logic rvalid_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// one strobe per frame result
	a_syn_v_pulse: assert property (@(posedge I_clk) disable iff (!rst_n_i)
		syn_v_i |=> !syn_v_i)
		else $error("syndrome_v_o high for more than one cycle");

	a_err_with_v: assert property (@(posedge I_clk) disable iff (!rst_n_i)
		err_i |-> syn_v_i)
		else $error("err_o high without syndrome_v_o");

	// read data exactly one cycle after the strobe
	a_rd_to_rvalid: assert property (@(posedge I_clk) disable iff (!rst_n_i)
		rd_i |=> rvalid_i)
		else $error("reg_rvalid_o missing after a read strobe");

	a_rvalid_from_rd: assert property (@(posedge I_clk) disable iff (!rst_n_i)
		rvalid_i |-> $past(rd_i))
		else $error("reg_rvalid_o without a read strobe one cycle before");

endmodule

bind bch_syndrome_top bch_syndrome_sva u_sva (
	.I_clk    (I_clk),
	.rst_n_i  (rst_n_i),
	.syn_v_i  (syndrome_v_o),
	.err_i    (err_o),
	.rd_i     (reg_rd_i),
	.rvalid_i (reg_rvalid_o)
);

// File: verif/tb_bch_syndrome.sv
// syndrome front end testbench with random frames, horner model, register checks and watchdog
module tb_bch_syndrome;
	timeunit 1ns;
	timeprecision 1ps;
	import bch_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_BEATS = 6;
	localparam int MAX_GAP = 3;
	localparam int NUM_FRAMES = 100; // all phases together
	localparam int TIMEOUT_NS = (NUM_FRAMES * (MAX_BEATS + MAX_GAP + 1) + 400) * CLK_PERIOD;
	// generator of the t=2 code x^12+x^10+x^8+x^5+x^4+x^3+1
	localparam logic [BEAT_W-1:0] T2_CODEWORD = 16'h1539;

	logic I_clk;
	logic rst_n_i;
	logic [BEAT_W-1:0] data_i;
	logic data_v_i;
	logic sof_i;
	logic eof_i;
	logic reg_wr_i;
	logic reg_rd_i;
	reg_addr_e reg_addr_i;
	logic [REG_W-1:0] reg_wdata_i;
	logic [NUM_SYN*GF_M-1:0] syndrome_o;
	logic syndrome_v_o;
	logic err_o;
	logic [REG_W-1:0] reg_rdata_o;
	logic reg_rvalid_o;

	integer seed = 67236;
	int cyc = 0;
	bit bits_q[$];                            // accepted bits with highest degree first
	logic [NUM_SYN*GF_M-1:0] exp_syn_q[$];
	logic exp_err_q[$];
	int exp_due_q[$];                         // cycle when the result is due
	bit model_en;
	int model_t;
	int model_frames;
	int model_errs;

	bch_syndrome_top DUT (
		.I_clk        (I_clk),
		.rst_n_i      (rst_n_i),
		.data_i       (data_i),
		.data_v_i     (data_v_i),
		.sof_i        (sof_i),
		.eof_i        (eof_i),
		.reg_wr_i     (reg_wr_i),
		.reg_rd_i     (reg_rd_i),
		.reg_addr_i   (reg_addr_i),
		.reg_wdata_i  (reg_wdata_i),
		.syndrome_o   (syndrome_o),
		.syndrome_v_o (syndrome_v_o),
		.err_o        (err_o),
		.reg_rdata_o  (reg_rdata_o),
		.reg_rvalid_o (reg_rvalid_o)
	);

	initial
	begin
		I_clk = 1'b0;
		forever #(CLK_PERIOD / 2) I_clk = ~I_clk;
	end

	always @(posedge I_clk)
		cyc <= cyc + 1;

	initial
	begin
		#(TIMEOUT_NS);
		fail_now("watchdog expired before the test sequence finished");
	end

	//------------------------------------------------------------
	// checking helpers
	//------------------------------------------------------------
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			fail_now($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic int urand(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// S(j) = r(alpha^j) evaluated bit by bit
	function automatic logic [NUM_SYN*GF_M-1:0] horner_syn(input int t);
		logic [NUM_SYN*GF_M-1:0] res;
		logic [GF_M-1:0] acc;
		logic [GF_M-1:0] root;
		res = '0;
		for (int j = 1; j <= NUM_SYN; j++)
		begin
			root = gf_pow_alpha(j);
			acc = '0;
			foreach (bits_q[i])
				acc = gf_mul(acc, root) ^ GF_M'(bits_q[i]);
			if (j <= 2 * t)
				res[(j-1)*GF_M +: GF_M] = acc; // above 2*t stays zero
		end
		return res;
	endfunction

	//------------------------------------------------------------
	// model and result checks sampled mid cycle
	//------------------------------------------------------------
	always @(negedge I_clk)
	begin
		logic [NUM_SYN*GF_M-1:0] syn;
		if (exp_due_q.size() > 0 && exp_due_q[0] == cyc)
		begin
			if (!syndrome_v_o)
				fail_now("no result strobe four cycles after an end-of-frame beat");
			check_val("syndrome_o", 64'(syndrome_o), 64'(exp_syn_q[0]));
			check_val("err_o", 64'(err_o), 64'(exp_err_q[0]));
			model_frames++;
			if (exp_err_q[0])
				model_errs++;
			void'(exp_syn_q.pop_front());
			void'(exp_err_q.pop_front());
			void'(exp_due_q.pop_front());
		end
		else if (syndrome_v_o)
			fail_now("result strobe without a matching frame");
		if (rst_n_i && data_v_i && model_en)
		begin
			if (sof_i)
				bits_q.delete();
			for (int i = BEAT_W - 1; i >= 0; i--)
				bits_q.push_back(data_i[i]);
			if (eof_i)
			begin
				syn = horner_syn(model_t);
				exp_syn_q.push_back(syn);
				exp_err_q.push_back(|syn);
				exp_due_q.push_back(cyc + 5); // sampled next edge plus 4 more
			end
		end
	end

	//------------------------------------------------------------
	// stimulus
	//------------------------------------------------------------
	task automatic send_frame;
		int len;
		int kind;
		int pos;
		int shift;
		int gap;
		logic [BEAT_W-1:0] beat;
		len = 1 + urand(MAX_BEATS);
		kind = urand(4); // random, all zero, single bit or t=2 codeword
		pos = urand(len * BEAT_W);
		shift = urand(BEAT_W - 12);
		gap = urand(MAX_GAP + 1);
		if (len == 1 && gap == 0)
			gap = 1; // keeps result strobes apart
		repeat (gap)
		begin
			@(posedge I_clk);
			data_v_i <= 1'b0;
			sof_i    <= 1'b0;
			eof_i    <= 1'b0;
		end
		for (int b = 0; b < len; b++)
		begin
			if (kind == 0)
				beat = BEAT_W'($random(seed));
			else if (kind == 1 || b != pos / BEAT_W)
				beat = '0;
			else if (kind == 2)
				beat = BEAT_W'(1) << (BEAT_W - 1 - pos % BEAT_W);
			else
				beat = T2_CODEWORD << shift; // roots alpha to alpha^4 only
			@(posedge I_clk);
			data_i   <= beat;
			data_v_i <= 1'b1;
			sof_i    <= (b == 0);
			eof_i    <= (b == len - 1);
		end
	endtask

	task automatic run_frames(input int n);
		repeat (n)
			send_frame();
	endtask

	task automatic drain;
		@(posedge I_clk);
		data_v_i <= 1'b0;
		sof_i    <= 1'b0;
		eof_i    <= 1'b0;
		@(negedge I_clk);
		while (exp_due_q.size() != 0)
			@(posedge I_clk);
		repeat (2) @(posedge I_clk); // counters take the last strobe
	endtask

	task automatic reg_write(input reg_addr_e addr, input logic [REG_W-1:0] wdata);
		int t;
		@(posedge I_clk);
		reg_wr_i    <= 1'b1;
		reg_addr_i  <= addr;
		reg_wdata_i <= wdata;
		@(posedge I_clk);
		reg_wr_i <= 1'b0;
		t = int'(wdata[T_W:1]);
		if (addr == REG_CTRL)
		begin
			model_en = wdata[0];
			model_t  = (t == 0 || t > CODE_T) ? CODE_T : t;
		end
		else if (addr == REG_CLEAR)
		begin
			model_frames = 0;
			model_errs   = 0;
		end
	endtask

	task automatic read_check(input reg_addr_e addr, input logic [REG_W-1:0] exp);
		@(posedge I_clk);
		reg_rd_i   <= 1'b1;
		reg_addr_i <= addr;
		@(posedge I_clk);
		reg_rd_i <= 1'b0;
		@(negedge I_clk);
		if (!reg_rvalid_o)
			fail_now("read data valid missing one cycle after the read strobe");
		check_val("reg_rdata_o", 64'(reg_rdata_o), 64'(exp));
		@(negedge I_clk);
		if (reg_rvalid_o)
			fail_now("read data valid stayed high after a single read");
	endtask

	task automatic check_counters;
		read_check(REG_FRAMES, REG_W'(model_frames));
		read_check(REG_ERRS, REG_W'(model_errs));
	endtask

	initial
	begin
		rst_n_i      = 1'b0;
		data_i       = '0;
		data_v_i     = 1'b0;
		sof_i        = 1'b0;
		eof_i        = 1'b0;
		reg_wr_i     = 1'b0;
		reg_rd_i     = 1'b0;
		reg_addr_i   = REG_CTRL;
		reg_wdata_i  = '0;
		model_en     = 1'b1;
		model_t      = CODE_T;
		model_frames = 0;
		model_errs   = 0;
		repeat (2) @(posedge I_clk);
		rst_n_i <= 1'b1;
		read_check(REG_CTRL, REG_W'((CODE_T << 1) | 1));
		check_counters();
		run_frames(40); // full capability
		drain();
		check_counters();
		reg_write(REG_CTRL, REG_W'((2 << 1) | 1)); // t_active = 2
		read_check(REG_CTRL, REG_W'((2 << 1) | 1));
		run_frames(20);
		drain();
		reg_write(REG_CTRL, REG_W'(1)); // zero t_active clamps
		read_check(REG_CTRL, REG_W'((CODE_T << 1) | 1));
		reg_write(REG_CTRL, REG_W'(0)); // beats ignored from here
		read_check(REG_CTRL, REG_W'(CODE_T << 1));
		run_frames(10);
		drain();
		check_counters();
		reg_write(REG_CTRL, REG_W'((CODE_T << 1) | 1));
		run_frames(20);
		drain();
		check_counters();
		reg_write(REG_CLEAR, REG_W'(0));
		check_counters();
		read_check(REG_CLEAR, REG_W'(0));
		run_frames(10);
		drain();
		check_counters();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: sim.f
source/bch_pkg.sv
source/bch_ctrl_if.sv
source/bch_syndrome_calc.sv
source/bch_syndrome_expand.sv
source/bch_regs.sv
source/bch_syndrome_top.sv
verif/bch_syndrome_sva.sv
verif/tb_bch_syndrome.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bch_syndrome
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -Wno-fatal
PASS_STR  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
